//--- ika_consts.svh
`ifndef IKA_CONSTS_SVH
`define IKA_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

`define IKA_AW              16  // address bus, PC and MA
`define IKA_DW              8   // port D data byte

//////////////////////////////////////////////////////////////////////
// cycle lengths, in pcen ticks
//////////////////////////////////////////////////////////////////////

`define IKA_PH_RD4          12  // opcode fetch, 4 states x 3
`define IKA_PH_3ST          9   // RD3, WR3 and IDLE

//////////////////////////////////////////////////////////////////////
// phase numbers, counted from the edge that enters the phase
//////////////////////////////////////////////////////////////////////

`define IKA_PH_ALE_OFF      1   // ALE low from here on
`define IKA_PH_STB_ON       2   // /RD or /WR goes low
`define IKA_PH_STB_OFF4     8   // /RD back high, RD4
`define IKA_PH_STB_OFF3     6   // /RD or /WR back high, 3-state
`define IKA_PH_SAMPLE       6   // port D latched on entry

`endif

//--- ika_pkg.sv
package ika_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus access kinds
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE = 2'b00,   // no strobes, no ALE
        RD4  = 2'b01,   // opcode fetch
        RD3  = 2'b10,   // operand / data read
        WR3  = 2'b11    // data write
    } bus_acc_e;

    // reduced instruction set, anything else runs as NOP
    typedef enum logic [7:0] {
        NOP   = 8'h00,
        LXIMD = 8'h01,  // MD <- imm16
        MOVMA = 8'h02,  // MA <- MD
        STMD  = 8'h03,  // (MA) <- MD, low byte first
        JMPMD = 8'h04,  // PC <- MD
        LDMD  = 8'h06   // MD <- (MA), low byte first
    } opcode_e;

    // register load applied at cycle end
    typedef enum logic [1:0] {
        NONE       = 2'd0,
        MA_FROM_MD = 2'd1,
        PC_FROM_MD = 2'd2
    } mc_dst_e;

    //////////////////////////////////////////////////////////////////////
    // microcode word and timing strobes
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        bus_acc_e next_acc;     // kind of the following bus cycle
        mc_dst_e  dst;          // load done at this cycle's end
        logic     use_ma;       // next cycle addresses through MA
    } mc_word_t;

    typedef struct packed {
        logic pcen;             // raw clock enable
        logic cycle_start;      // phase 0 with pcen
        logic cycle_end;        // last phase with pcen
        logic sample;           // read data valid, latch port D
        logic strobe_on;        // /RD or /WR assert edge
        logic strobe_off;       // strobe release edge
    } tick_t;

    typedef logic [3:0] phase_t;    // phase index 0..11

endpackage

//--- ika_timing.sv
`include "ika_consts.svh"

module ika_timing import ika_pkg::*; (
    input  logic     i_emuclk,
    input  logic     i_mrst_n,
    input  logic     i_mcuclk_pcen,
    input  bus_acc_e i_next_acc,    // from microcode and taken at cycle end
    output tick_t    o_tick,
    output phase_t   o_phase,
    output bus_acc_e o_cur_acc
);

    localparam int PH = `IKA_PH_RD4;

    // parked on the last phase of an idle cycle so the first pcen opens the fetch
    localparam logic [PH-1:0] SR_RST = PH'(1) << (`IKA_PH_3ST - 1);

    logic [PH-1:0] phase_sr;    // one-hot phase
    bus_acc_e      cur_acc;
    logic          last_ph;     // final phase of current cycle
    logic          off_ph;      // phase just before strobe release

    assign last_ph = (cur_acc == RD4) ? phase_sr[`IKA_PH_RD4-1] : phase_sr[`IKA_PH_3ST-1];
    assign off_ph  = (cur_acc == RD4) ? phase_sr[`IKA_PH_STB_OFF4-1]
                                      : phase_sr[`IKA_PH_STB_OFF3-1];

    always_ff @(posedge i_emuclk) begin
        if (!i_mrst_n) begin
            phase_sr <= SR_RST;
            cur_acc  <= IDLE;
        end else if (i_mcuclk_pcen) begin
            if (last_ph) begin
                phase_sr <= PH'(1);         // wrap to phase 0
                cur_acc  <= i_next_acc;     // next cycle kind taken without delay
            end else begin
                phase_sr <= {phase_sr[PH-2:0], 1'b0};
            end
        end
    end

    // one-hot to index for the bus controller
    always_comb begin
        o_phase = '0;
        for (int i = 0; i < PH; i++) begin
            if (phase_sr[i]) o_phase = phase_t'(i);
        end
    end

    // sample and strobe ticks are edges entering the named phase
    always_comb begin
        o_tick.pcen        = i_mcuclk_pcen;
        o_tick.cycle_start = i_mcuclk_pcen & phase_sr[0];
        o_tick.cycle_end   = i_mcuclk_pcen & last_ph;
        o_tick.sample      = i_mcuclk_pcen & phase_sr[`IKA_PH_SAMPLE-1]
                           & (cur_acc == RD4 || cur_acc == RD3);
        o_tick.strobe_on   = i_mcuclk_pcen & phase_sr[`IKA_PH_STB_ON-1] & (cur_acc != IDLE);
        o_tick.strobe_off  = i_mcuclk_pcen & off_ph;
    end

    assign o_cur_acc = cur_acc;

    a_phase_onehot: assert property (@(posedge i_emuclk) disable iff (!i_mrst_n)
        $onehot(phase_sr));

endmodule

//--- ika_microseq.sv
module ika_microseq import ika_pkg::*; (
    input  logic     i_emuclk,
    input  logic     i_mrst_n,
    input  tick_t    i_tick,
    input  logic [7:0] i_opcode,    // latched during fetch
    output mc_word_t o_mc
);

    opcode_e    op;
    logic [1:0] step;   // cycle index inside the instruction

    //////////////////////////////////////////////////////////////////////
    // opcode decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_opcode)
            LXIMD, MOVMA, STMD, JMPMD, LDMD: op = opcode_e'(i_opcode);
            default:                         op = NOP;   // unknown, single fetch
        endcase
    end

    // step 0 is the fetch itself, restart whenever the next cycle is a fetch
    always_ff @(posedge i_emuclk) begin
        if (!i_mrst_n) begin
            step <= 2'd0;
        end else if (i_tick.cycle_end) begin
            if (o_mc.next_acc == RD4) step <= 2'd0;
            else                      step <= step + 2'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // step ROM, each entry picks the cycle after the current one
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        o_mc.next_acc = RD4;    // default: back to fetch through PC
        o_mc.dst      = NONE;
        o_mc.use_ma   = 1'b0;
        case (op)
            LXIMD: begin
                if (step < 2'd2) o_mc.next_acc = RD3;     // two immediates via PC
            end
            MOVMA: begin
                if (step == 2'd0) o_mc.next_acc = IDLE;
                else              o_mc.dst      = MA_FROM_MD;
            end
            JMPMD: begin
                if (step == 2'd0) o_mc.next_acc = IDLE;
                else              o_mc.dst      = PC_FROM_MD;  // beats the fetch increment
            end
            STMD: begin
                if (step < 2'd2) begin
                    o_mc.next_acc = WR3;
                    o_mc.use_ma   = 1'b1;
                end
            end
            LDMD: begin
                if (step < 2'd2) begin
                    o_mc.next_acc = RD3;
                    o_mc.use_ma   = 1'b1;
                end
            end
            default: ;  // NOP
        endcase
    end

    // longest instruction is three cycles
    a_step_max: assert property (@(posedge i_emuclk) disable iff (!i_mrst_n)
        step <= 2'd2);

endmodule

//--- ika_addr_unit.sv
`include "ika_consts.svh"

module ika_addr_unit import ika_pkg::*; (
    input  logic               i_emuclk,
    input  logic               i_mrst_n,
    input  tick_t              i_tick,
    input  bus_acc_e           i_cur_acc,
    input  mc_word_t           i_mc,
    input  logic [`IKA_AW-1:0] i_md,
    output logic [`IKA_AW-1:0] o_addr
);

    logic [`IKA_AW-1:0] pc;
    logic [`IKA_AW-1:0] ma;
    logic               src_ma;     // 0 = PC drives the bus, 1 = MA

    //////////////////////////////////////////////////////////////////////
    // address source
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_emuclk) begin
        if (!i_mrst_n) begin
            src_ma <= 1'b0;
        end else if (i_tick.cycle_end) begin
            src_ma <= i_mc.use_ma;  // holds for the whole next cycle
        end
    end

    //////////////////////////////////////////////////////////////////////
    // PC / MA, all updates on the cycle end edge
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_emuclk) begin
        if (!i_mrst_n) begin
            pc <= '0;
            ma <= '0;
        end else if (i_tick.cycle_end) begin
            // program counter
            if (i_mc.dst == PC_FROM_MD) begin
                pc <= i_md;
            end else if (i_cur_acc == RD4) begin
                pc <= pc + 1'b1;                    // past the opcode
            end else if (i_cur_acc == RD3 && !src_ma) begin
                pc <= pc + 1'b1;                    // immediate byte
            end

            // memory address
            if (i_mc.dst == MA_FROM_MD) begin
                ma <= i_md;
            end else if (i_cur_acc == WR3 || (i_cur_acc == RD3 && src_ma)) begin
                ma <= ma + 1'b1;                    // wraps at 64k
            end
        end
    end

    assign o_addr = src_ma ? ma : pc;

endmodule

//--- ika_bus_ctrl.sv
`include "ika_consts.svh"

module ika_bus_ctrl import ika_pkg::*; (
    input  logic               i_emuclk,
    input  logic               i_mrst_n,
    input  tick_t              i_tick,
    input  phase_t             i_phase,
    input  bus_acc_e           i_cur_acc,
    input  logic [`IKA_AW-1:0] i_addr,
    input  logic [`IKA_DW-1:0] i_pd_i,
    output logic [7:0]         o_opcode,
    output logic [`IKA_AW-1:0] o_md,
    output logic               o_ale,
    output logic               o_rd_n,
    output logic               o_wr_n,
    output logic [`IKA_DW-1:0] o_pc_o,
    output logic [`IKA_DW-1:0] o_pd_o,
    output logic [`IKA_DW-1:0] o_pd_dir
);

    logic [7:0]         opcode_q;
    logic [`IKA_AW-1:0] md_q;
    logic               in_sel;     // next MD byte to fill, 0 = low
    logic               out_sel;    // next MD byte to write, 0 = low
    logic               rd_q;       // active high internally
    logic               wr_q;
    logic [`IKA_DW-1:0] md_byte;

    //////////////////////////////////////////////////////////////////////
    // opcode and MD input latches
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_emuclk) begin
        if (!i_mrst_n) begin
            opcode_q <= NOP;
            md_q     <= '0;
            in_sel   <= 1'b0;
        end else begin
            if (i_tick.cycle_start && i_cur_acc == RD4) begin
                in_sel <= 1'b0;     // new instruction, low byte first
            end
            if (i_tick.sample) begin
                if (i_cur_acc == RD4) begin
                    opcode_q <= i_pd_i;
                end else begin      // RD3
                    if (in_sel) md_q[15:8] <= i_pd_i;
                    else        md_q[7:0]  <= i_pd_i;
                    in_sel <= ~in_sel;
                end
            end
        end
    end

    // write byte order, low then high across consecutive WR3
    always_ff @(posedge i_emuclk) begin
        if (!i_mrst_n) begin
            out_sel <= 1'b0;
        end else if (i_tick.cycle_start && i_cur_acc == RD4) begin
            out_sel <= 1'b0;
        end else if (i_tick.cycle_end && i_cur_acc == WR3) begin
            out_sel <= ~out_sel;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_emuclk) begin
        if (!i_mrst_n) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else if (i_tick.strobe_on) begin
            rd_q <= (i_cur_acc == RD4 || i_cur_acc == RD3);
            wr_q <= (i_cur_acc == WR3);
        end else if (i_tick.strobe_off) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end
    end

    // ALE over phase 0 only, none on idle cycles
    assign o_ale  = (i_cur_acc != IDLE) && (i_phase < phase_t'(`IKA_PH_ALE_OFF));
    assign o_rd_n = ~rd_q;
    assign o_wr_n = ~wr_q;

    //////////////////////////////////////////////////////////////////////
    // port C / port D
    //////////////////////////////////////////////////////////////////////

    assign md_byte = out_sel ? md_q[15:8] : md_q[7:0];
    assign o_pc_o  = i_addr[15:8];  // high address, whole cycle

    always_comb begin
        if (i_cur_acc == WR3 && i_phase >= phase_t'(`IKA_PH_STB_ON)) begin
            o_pd_o = md_byte;           // write data after address phase
        end else begin
            o_pd_o = i_addr[7:0];       // multiplexed low address
        end
    end

    assign o_pd_dir = rd_q ? '0 : '1;   // input only while /RD low
    assign o_opcode = opcode_q;
    assign o_md     = md_q;

    a_rd_wr_excl: assert property (@(posedge i_emuclk) disable iff (!i_mrst_n)
        !(rd_q && wr_q));

    a_ale_vs_stb: assert property (@(posedge i_emuclk) disable iff (!i_mrst_n)
        !(o_ale && (rd_q || wr_q)));

endmodule

//--- ika87_core.sv
`include "ika_consts.svh"

module ika87_core import ika_pkg::*; (
    input  logic               i_emuclk,
    input  logic               i_mcuclk_pcen,
    input  logic               i_mrst_n,
    input  logic [`IKA_DW-1:0] i_pd_i,
    output logic               o_ale,
    output logic               o_rd_n,
    output logic               o_wr_n,
    output logic [`IKA_DW-1:0] o_pc_o,
    output logic [`IKA_DW-1:0] o_pd_o,
    output logic [`IKA_DW-1:0] o_pd_dir
);

    tick_t              tick;
    phase_t             phase;
    bus_acc_e           cur_acc;
    mc_word_t           mc;
    logic [7:0]         opcode;     // fed back to the sequencer
    logic [`IKA_AW-1:0] md;
    logic [`IKA_AW-1:0] addr;

    ika_timing u_timing (
        .i_emuclk      (i_emuclk),
        .i_mrst_n      (i_mrst_n),
        .i_mcuclk_pcen (i_mcuclk_pcen),
        .i_next_acc    (mc.next_acc),
        .o_tick        (tick),
        .o_phase       (phase),
        .o_cur_acc     (cur_acc)
    );

    ika_microseq u_microseq (
        .i_emuclk (i_emuclk),
        .i_mrst_n (i_mrst_n),
        .i_tick   (tick),
        .i_opcode (opcode),
        .o_mc     (mc)
    );

    ika_addr_unit u_addr_unit (
        .i_emuclk  (i_emuclk),
        .i_mrst_n  (i_mrst_n),
        .i_tick    (tick),
        .i_cur_acc (cur_acc),
        .i_mc      (mc),
        .i_md      (md),
        .o_addr    (addr)
    );

    ika_bus_ctrl u_bus_ctrl (
        .i_emuclk  (i_emuclk),
        .i_mrst_n  (i_mrst_n),
        .i_tick    (tick),
        .i_phase   (phase),
        .i_cur_acc (cur_acc),
        .i_addr    (addr),
        .i_pd_i    (i_pd_i),
        .o_opcode  (opcode),
        .o_md      (md),
        .o_ale     (o_ale),
        .o_rd_n    (o_rd_n),
        .o_wr_n    (o_wr_n),
        .o_pc_o    (o_pc_o),
        .o_pd_o    (o_pd_o),
        .o_pd_dir  (o_pd_dir)
    );

endmodule

//--- tb_ika87_core.sv
`include "ika_consts.svh"

module tb_ika87_core import ika_pkg::*; ();

    localparam int NUM_INSTR    = 300;
    localparam int TIMEOUT_CLKS = NUM_INSTR * 3 * `IKA_PH_RD4 * 2 + 2000;  // pcen ~3/4
    localparam int W_RD4        = `IKA_PH_STB_OFF4 - `IKA_PH_STB_ON;   // strobe ticks in a fetch
    localparam int W_3ST        = `IKA_PH_STB_OFF3 - `IKA_PH_STB_ON;   // strobe ticks in RD3/WR3

    logic        emuclk;
    logic        mcuclk_pcen;
    logic        mrst_n;
    logic [7:0]  pd_i;
    logic        ale;
    logic        rd_n;
    logic        wr_n;
    logic [7:0]  pc_o;
    logic [7:0]  pd_o;
    logic [7:0]  pd_dir;

    logic [7:0]  mem [0:65535];         // external memory on the bus
    logic [7:0]  exp_mem [0:65535];     // model view of the same memory
    integer      seed = 3;
    logic [15:0] gen_pos;
    int          tick_cnt = 0;          // pcen ticks seen so far
    int          clk_cnt = 0;

    // bus monitor state
    logic [15:0] lat_addr = '0;
    logic [7:0]  wr_data = '0;
    logic        ale_q = 1'b0;
    logic        rd_n_q = 1'b1;
    logic        wr_n_q = 1'b1;
    logic        seen_ale = 1'b0;
    int          start_tick = 0;
    int          stb_tick = 0;
    bit          cyc_wr_q [$];          // one entry per strobed bus cycle
    logic [15:0] cyc_addr_q [$];
    logic [7:0]  cyc_data_q [$];
    int          cyc_width_q [$];
    int          span_q [$];            // ticks from one ALE rise to the next
    int          prev_span = -1;

    ika87_core UUT (
        .i_emuclk      (emuclk),
        .i_mcuclk_pcen (mcuclk_pcen),
        .i_mrst_n      (mrst_n),
        .i_pd_i        (pd_i),
        .o_ale         (ale),
        .o_rd_n        (rd_n),
        .o_wr_n        (wr_n),
        .o_pc_o        (pc_o),
        .o_pd_o        (pd_o),
        .o_pd_dir      (pd_dir)
    );

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected 0x%0h, got 0x%0h", name, exp_v, act_v);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // memory image and random program
    //////////////////////////////////////////////////////////////////////

    task automatic put_byte(input logic [7:0] b);
        mem[gen_pos]     = b;
        exp_mem[gen_pos] = b;
        gen_pos          = gen_pos + 16'd1;
    endtask

    task automatic put_lximd(input logic [15:0] w);
        put_byte(LXIMD);
        put_byte(w[7:0]);   // low byte first
        put_byte(w[15:8]);
    endtask

    task automatic gen_program();
        int          i;
        int          n;
        int          gap;
        logic [15:0] a;
        logic [7:0]  b;
        for (i = 0; i < 65536; i++) begin
            if (i < 'h1000) b = 8'h00;                  // program area with NOPs past the end
            else if (i >= 'h8000 && i < 'h9000) b = 8'(rand_below(256));
            else b = i[15:8] ^ i[7:0];
            mem[i]     = b;
            exp_mem[i] = b;
        end
        gen_pos = '0;
        n       = 0;
        while (n < NUM_INSTR) begin
            a = 16'h8000 + 16'(rand_below('h0ff0));     // leaves room for MA+4
            case (rand_below(4))
                0: begin                                // NOP or an unused opcode
                    b = 8'(rand_below(256));
                    if (b inside {LXIMD, MOVMA, STMD, JMPMD, LDMD}) b = NOP;
                    put_byte(b);
                    n += 1;
                end
                1: begin                                // two stores while MA runs on
                    put_lximd(a);
                    put_byte(MOVMA);
                    put_lximd(16'(rand_below(65536)));
                    put_byte(STMD);
                    put_lximd(16'(rand_below(65536)));
                    put_byte(STMD);
                    n += 6;
                end
                2: begin                                // copy a word
                    put_lximd(a);
                    put_byte(MOVMA);
                    put_byte(LDMD);
                    put_lximd(16'h8000 + 16'(rand_below('h0ff0)));
                    put_byte(MOVMA);
                    put_byte(STMD);
                    n += 6;
                end
                default: begin                          // forward jump over junk
                    gap = rand_below(4);
                    put_lximd(gen_pos + 16'd4 + 16'(gap));
                    put_byte(JMPMD);
                    repeat (gap) put_byte(8'hff);
                    n += 2;
                end
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model stepping one instruction at a time
    //////////////////////////////////////////////////////////////////////

    task automatic expect_cycle(input bit exp_wr, input logic [15:0] exp_addr,
                                input int exp_width, input logic [7:0] exp_data,
                                input int exp_span);
        logic [7:0] data;
        while (cyc_addr_q.size() == 0) @(negedge emuclk);
        if (prev_span >= 0) begin
            check_val("cycle_ticks", prev_span, span_q.pop_front());   // previous cycle length
        end
        check_val("bus_write", 32'(exp_wr), 32'(cyc_wr_q.pop_front()));
        check_val("bus_addr", 32'(exp_addr), 32'(cyc_addr_q.pop_front()));
        check_val("strobe_ticks", exp_width, cyc_width_q.pop_front());
        data = cyc_data_q.pop_front();
        if (exp_wr) check_val("wr_data", 32'(exp_data), 32'(data));
        prev_span = exp_span;
    endtask

    task automatic run_model();
        logic [15:0] pc;
        logic [15:0] ma;
        logic [15:0] md;
        logic [7:0]  op;
        pc = '0;
        ma = '0;
        md = '0;
        repeat (NUM_INSTR) begin
            op = exp_mem[pc];
            expect_cycle(1'b0, pc, W_RD4, 8'h00, (op == MOVMA || op == JMPMD) ?
                         `IKA_PH_RD4 + `IKA_PH_3ST : `IKA_PH_RD4);   // idle cycle has no ALE
            pc = pc + 16'd1;
            case (op)
                LXIMD: begin
                    expect_cycle(1'b0, pc, W_3ST, 8'h00, `IKA_PH_3ST);
                    expect_cycle(1'b0, pc + 16'd1, W_3ST, 8'h00, `IKA_PH_3ST);
                    md = {exp_mem[pc + 16'd1], exp_mem[pc]};
                    pc = pc + 16'd2;
                end
                MOVMA: ma = md;
                JMPMD: pc = md;
                STMD, LDMD: begin
                    expect_cycle(op == STMD, ma, W_3ST, md[7:0], `IKA_PH_3ST);
                    expect_cycle(op == STMD, ma + 16'd1, W_3ST, md[15:8], `IKA_PH_3ST);
                    if (op == STMD) begin
                        exp_mem[ma]         = md[7:0];
                        exp_mem[ma + 16'd1] = md[15:8];
                    end else begin
                        md = {exp_mem[ma + 16'd1], exp_mem[ma]};
                    end
                    ma = ma + 16'd2;
                end
                default: ;  // NOP and unused opcodes
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, stimulus, monitor
    //////////////////////////////////////////////////////////////////////

    initial begin
        emuclk = 1'b0;
        forever #20 emuclk = ~emuclk;
    end

    initial begin
        mrst_n      = 1'b0;
        mcuclk_pcen = 1'b0;
        pd_i        = 8'hff;
        gen_program();
        repeat (2) @(posedge emuclk);
        #5;
        mrst_n = 1'b1;
        check_val("o_ale", 32'd0, 32'(ale));    // reset state
        check_val("o_rd_n", 32'd1, 32'(rd_n));
        check_val("o_wr_n", 32'd1, 32'(wr_n));
        forever begin
            @(posedge emuclk);
            #5;
            mcuclk_pcen = (rand_below(4) != 0);     // about 3 in 4
            pd_i = !rd_n ? mem[lat_addr] : 8'hff;   // memory answers while /RD low
        end
    end

    always @(posedge emuclk) begin
        tick_cnt <= tick_cnt + int'(mcuclk_pcen);
        clk_cnt  <= clk_cnt + 1;
        if (clk_cnt >= TIMEOUT_CLKS) begin
            $display("Timeout: bus trace not finished after %0d clocks", TIMEOUT_CLKS);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    always @(negedge emuclk) begin
        if (mrst_n) begin
            check_val("rd_wr_overlap", 32'd0, 32'(!rd_n && !wr_n));
            check_val("ale_in_strobe", 32'd0, 32'(ale && (!rd_n || !wr_n)));
            check_val("o_pd_dir", rd_n ? 32'hff : 32'h00, 32'(pd_dir));
            if (ale && !ale_q) begin                // cycle start
                if (seen_ale) span_q.push_back(tick_cnt - start_tick);
                start_tick = tick_cnt;
                seen_ale   = 1'b1;
            end
            if (ale) lat_addr = {pc_o, pd_o};       // latch open while ALE high
            if (!ale && ale_q) begin                // ALE drops after phase 0
                check_val("ale_ticks", `IKA_PH_ALE_OFF, tick_cnt - start_tick);
            end
            if (!rd_n || !wr_n) begin
                check_val("o_pc_o", 32'(lat_addr[15:8]), 32'(pc_o));
            end
            if ((!rd_n && rd_n_q) || (!wr_n && wr_n_q)) begin
                check_val("strobe_phase", `IKA_PH_STB_ON, tick_cnt - start_tick);
                stb_tick = tick_cnt;
            end
            if (!wr_n) wr_data = pd_o;
            if ((rd_n && !rd_n_q) || (wr_n && !wr_n_q)) begin
                if (!wr_n_q) mem[lat_addr] = wr_data;   // write lands at /WR rise
                cyc_wr_q.push_back(!wr_n_q);
                cyc_addr_q.push_back(lat_addr);
                cyc_data_q.push_back(wr_data);
                cyc_width_q.push_back(tick_cnt - stb_tick);
            end
            ale_q  = ale;
            rd_n_q = rd_n;
            wr_n_q = wr_n;
        end
    end

    initial begin
        @(posedge mrst_n);
        run_model();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
ika_pkg.sv
ika_timing.sv
ika_microseq.sv
ika_addr_unit.sv
ika_bus_ctrl.sv
ika87_core.sv
tb_ika87_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_ika87_core
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
